/* rtl/busMaster_macros.svh */
`ifndef BUS_MASTER_MACROS_SVH
`define BUS_MASTER_MACROS_SVH

// byte width on display and on the write line
`define DATA_WIDTH 8

// cycles a byte stays on the display after its first cycle
`define DISPLAY_CYCLES 5

`define CTRL_PREFIX 3'b111  // start marker of request and control frames
`define ACK_CODE 8'hCC      // upper reply byte that accepts a round
`define START_BYTE 8'h0A    // first byte shown after start

`endif

/* rtl/busMaster_pkg.sv */
`include "busMaster_macros.svh"

package busMaster_pkg;

    typedef logic [`DATA_WIDTH-1:0] dataT;
    typedef logic [2*`DATA_WIDTH-1:0] rxWordT;  // ack byte over data byte
    typedef logic [2:0] slaveIdT;

    ////////////////////
    // link traffic
    ////////////////////

    typedef struct packed {
        logic start;         // one-cycle pulse
        logic readNotWrite;
        dataT wrByte;
    } frameReqT;

    typedef struct packed {
        logic   done;        // one-cycle pulse
        rxWordT rxWord;
    } frameRspT;

    typedef struct packed {
        logic reqBus;
        logic relBus;        // before a grant this withdraws the request
    } arbCmdT;

    typedef struct packed {
        logic granted;
        logic released;
    } arbRspT;

    ////////////////////
    // state machines
    ////////////////////

    typedef enum logic [2:0] {
        mConfigure, mIdle, mDisplay, mWriteRound, mReadRound, mCheckAck, mEnded
    } masterStateT;

    typedef enum logic [2:0] {
        arbIdle, arbWaitFree, arbSendReq, arbWaitGrant, arbAck, arbRelease
    } arbStateT;

    typedef enum logic [2:0] {
        linkIdle, linkCtrl, linkWrite, linkRead, linkStop, linkDone
    } linkStateT;

endpackage

/* rtl/arbiterLink.sv */
`timescale 1ns/10ps
`include "busMaster_macros.svh"

module arbiterLink import busMaster_pkg::*; #(
    parameter slaveIdT SLAVE_ID = 3'b101
) (
    input  logic   clk,
    input  logic   rstN,
    input  logic   arbCont,
    input  arbCmdT cmd,
    output logic   arbSend,
    output arbRspT rsp
);

    arbStateT   state;
    logic [5:0] reqShift;
    logic [2:0] bitCnt;
    logic [1:0] arbHist;    // two most recent arbCont samples

    wire [5:0] reqWord = {`CTRL_PREFIX, SLAVE_ID};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= arbIdle;
            reqShift <= '0;
            bitCnt   <= '0;
            arbHist  <= '0;
            arbSend  <= 1'b0;
            rsp      <= '0;
        end else begin
            arbHist <= {arbHist[0], arbCont};
            rsp     <= '0;
            if (cmd.relBus && state != arbIdle && state != arbRelease) begin
                // request withdrawn before the grant completed
                state   <= arbIdle;
                arbSend <= 1'b0;
            end else begin
                case (state)
                    arbIdle: begin
                        arbSend <= 1'b0;
                        bitCnt  <= '0;
                        if (cmd.reqBus) state <= arbWaitFree;
                        else if (cmd.relBus) state <= arbRelease;
                    end
                    arbWaitFree: if (!arbCont) begin  // first bit goes out once the bus is quiet
                        arbSend  <= reqWord[5];
                        reqShift <= {reqWord[4:0], 1'b0};
                        bitCnt   <= 3'd1;
                        state    <= arbSendReq;
                    end
                    arbSendReq: begin
                        arbSend  <= reqShift[5];
                        reqShift <= {reqShift[4:0], 1'b0};
                        bitCnt   <= bitCnt + 3'd1;
                        if (bitCnt == 3'd5) state <= arbWaitGrant;
                    end
                    arbWaitGrant: begin
                        arbSend <= 1'b0;
                        if (arbHist == 2'b11) begin
                            arbSend <= 1'b1;    // ack pattern 1 0 1
                            bitCnt  <= '0;
                            state   <= arbAck;
                        end
                    end
                    arbAck: begin
                        bitCnt  <= bitCnt + 3'd1;
                        arbSend <= (bitCnt == 3'd1);
                        if (bitCnt == 3'd2) begin
                            rsp.granted <= 1'b1;
                            state       <= arbIdle;
                        end
                    end
                    arbRelease: begin   // 0 went out on entry and 1 1 0 follow
                        bitCnt  <= bitCnt + 3'd1;
                        arbSend <= (bitCnt != 3'd2);
                        if (bitCnt == 3'd2) begin
                            rsp.released <= 1'b1;
                            state        <= arbIdle;
                        end
                    end
                    default: state <= arbIdle;
                endcase
            end
        end
    end

endmodule

/* rtl/slaveLink.sv */
`timescale 1ns/10ps
`include "busMaster_macros.svh"

module slaveLink import busMaster_pkg::*; #(
    parameter slaveIdT SLAVE_ID = 3'b101
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     rD,
    input  logic     ready,
    input  frameReqT req,
    output logic     control,
    output logic     wrD,
    output logic     valid,
    output frameRspT rsp
);

    localparam int cntW = $clog2(2 * `DATA_WIDTH);

    linkStateT         state;
    logic      [6:0]   ctrlShift;
    logic [cntW-1:0]   bitCnt;
    dataT              txShift;
    logic              isRead;

    // prefix, address, then 1 for write and 0 for read
    wire [6:0] ctrlWord = {`CTRL_PREFIX, SLAVE_ID, ~req.readNotWrite};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= linkIdle;
            ctrlShift <= '0;
            bitCnt    <= '0;
            txShift   <= '0;
            isRead    <= 1'b0;
            control   <= 1'b0;
            wrD       <= 1'b0;
            valid     <= 1'b0;
            rsp       <= '0;
        end else begin
            rsp.done <= 1'b0;
            case (state)
                linkIdle: begin
                    control <= 1'b0;
                    valid   <= 1'b0;
                    wrD     <= 1'b0;
                    if (req.start) begin
                        control   <= ctrlWord[6];
                        ctrlShift <= {ctrlWord[5:0], 1'b0};
                        txShift   <= req.wrByte;
                        isRead    <= req.readNotWrite;
                        bitCnt    <= cntW'(1);
                        state     <= linkCtrl;
                    end
                end

                ////////////////////
                // control word
                ////////////////////
                linkCtrl: begin
                    control   <= ctrlShift[6];
                    ctrlShift <= {ctrlShift[5:0], 1'b0};
                    bitCnt    <= bitCnt + 1'b1;
                    if (bitCnt == cntW'(6)) begin     // last of 7 bits
                        bitCnt <= '0;
                        state  <= isRead ? linkRead : linkWrite;
                    end
                end

                ////////////////////
                // data phase
                ////////////////////
                linkWrite: begin
                    control <= 1'b0;
                    valid   <= 1'b1;
                    wrD     <= txShift[`DATA_WIDTH-1];      // msb first
                    txShift <= {txShift[`DATA_WIDTH-2:0], 1'b0};
                    bitCnt  <= bitCnt + 1'b1;
                    if (bitCnt == cntW'(`DATA_WIDTH - 1)) state <= linkStop;
                end
                linkRead: begin
                    control <= 1'b0;
                    if (ready) begin    // slave stalls by dropping ready
                        rsp.rxWord <= {rsp.rxWord[2*`DATA_WIDTH-2:0], rD};
                        bitCnt     <= bitCnt + 1'b1;
                        if (bitCnt == cntW'(2 * `DATA_WIDTH - 1)) state <= linkStop;
                    end
                end

                linkStop: begin
                    valid   <= 1'b0;
                    wrD     <= 1'b0;
                    control <= 1'b1;    // stop bit
                    state   <= linkDone;
                end
                linkDone: begin
                    control  <= 1'b0;
                    rsp.done <= 1'b1;
                    state    <= linkIdle;
                end
                default: state <= linkIdle;
            endcase
        end
    end

endmodule

/* rtl/masterCtrl.sv */
`timescale 1ns/10ps
`include "busMaster_macros.svh"

module masterCtrl import busMaster_pkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       start,
    input  logic       eoc,
    input  arbRspT     arbRsp,
    input  frameRspT   frameRsp,
    output arbCmdT     arbCmd,
    output frameReqT   frameReq,
    output logic [1:0] doneCom,
    output dataT       dataOut,
    output logic       disData
);

    localparam int dispW = $clog2(`DISPLAY_CYCLES + 1);

    // steps inside one bus round
    localparam logic [1:0] stepReq     = 2'd0;
    localparam logic [1:0] stepGrant   = 2'd1;
    localparam logic [1:0] stepFrame   = 2'd2;
    localparam logic [1:0] stepRelease = 2'd3;

    masterStateT        state;
    logic [1:0]         step;
    logic [dispW-1:0]   dispCnt;

    wire ackOk   = (frameRsp.rxWord[2*`DATA_WIDTH-1 -: `DATA_WIDTH] == `ACK_CODE);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= mConfigure;
            step     <= stepReq;
            dispCnt  <= '0;
            arbCmd   <= '0;
            frameReq <= '0;
            doneCom  <= 2'b00;
            dataOut  <= '0;
            disData  <= 1'b0;
        end else begin
            arbCmd         <= '0;
            frameReq.start <= 1'b0;
            case (state)
                mConfigure: if (start) state <= mIdle;

                mIdle: begin
                    if (start) begin
                        dataOut <= `START_BYTE;
                        disData <= 1'b1;
                        dispCnt <= '0;
                        doneCom <= 2'b11;
                        state   <= mDisplay;
                    end else if (eoc) begin
                        doneCom <= 2'b01;
                        state   <= mEnded;
                    end else begin
                        step  <= stepReq;
                        state <= mReadRound;
                    end
                end

                ////////////////////
                // display phase
                ////////////////////
                mDisplay: begin
                    dispCnt <= dispCnt + 1'b1;
                    if (dispCnt == dispW'(`DISPLAY_CYCLES)) begin
                        disData <= 1'b0;
                        dispCnt <= '0;
                        step    <= stepReq;
                        state   <= mWriteRound;
                    end
                end

                ////////////////////
                // bus rounds
                ////////////////////
                mWriteRound, mReadRound: begin
                    if (eoc && (step == stepReq || step == stepGrant)) begin
                        // pull the request back while still waiting on the arbiter
                        arbCmd.relBus <= (step == stepGrant);
                        doneCom       <= 2'b01;
                        state         <= mEnded;
                    end else begin
                        case (step)
                            stepReq: begin
                                arbCmd.reqBus <= 1'b1;
                                step          <= stepGrant;
                            end
                            stepGrant: if (arbRsp.granted) begin
                                frameReq.start        <= 1'b1;
                                frameReq.readNotWrite <= (state == mReadRound);
                                frameReq.wrByte       <= dataOut + 1'b1;  // next byte
                                step                  <= stepFrame;
                            end
                            stepFrame: if (frameRsp.done) begin
                                arbCmd.relBus <= 1'b1;
                                step          <= stepRelease;
                            end
                            stepRelease: if (arbRsp.released) begin
                                step  <= stepReq;
                                state <= (state == mWriteRound) ? mReadRound : mCheckAck;
                            end
                        endcase
                    end
                end

                mCheckAck: begin
                    if (ackOk) begin
                        dataOut <= frameRsp.rxWord[`DATA_WIDTH-1:0];
                        disData <= 1'b1;
                        dispCnt <= '0;
                        doneCom <= 2'b11;
                        state   <= mDisplay;
                    end else begin
                        doneCom <= 2'b01;   // bad ack code
                        state   <= mEnded;
                    end
                end

                mEnded: disData <= 1'b0;   // dataOut keeps the last byte

                default: state <= mConfigure;
            endcase
        end
    end

endmodule

/* rtl/masterExternal.sv */
`timescale 1ns/10ps

module masterExternal import busMaster_pkg::*; #(
    parameter slaveIdT SLAVE_ID = 3'b101
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       start,
    input  logic       eoc,
    input  logic       rD,
    input  logic       ready,
    input  logic       arbCont,
    output logic [1:0] doneCom,
    output dataT       dataOut,
    output logic       disData,
    output logic       control,
    output logic       wrD,
    output logic       valid,
    output logic       arbSend
);

    arbCmdT   arbCmd;
    arbRspT   arbRsp;
    frameReqT frameReq;
    frameRspT frameRsp;

    arbiterLink #(.SLAVE_ID(SLAVE_ID)) u_arb (
        .clk, .rstN, .arbCont, .cmd(arbCmd), .arbSend, .rsp(arbRsp)
    );

    slaveLink #(.SLAVE_ID(SLAVE_ID)) u_link (
        .clk, .rstN, .rD, .ready, .req(frameReq),
        .control, .wrD, .valid, .rsp(frameRsp)
    );

    masterCtrl u_ctrl (
        .clk, .rstN, .start, .eoc, .arbRsp, .frameRsp,
        .arbCmd, .frameReq, .doneCom, .dataOut, .disData
    );

endmodule

/* tb/masterExternal_props.sv */
`timescale 1ns/10ps
`include "busMaster_macros.svh"

module masterExternal_props (
    input logic       clk,
    input logic       rstN,
    input logic       valid,
    input logic       control,
    input logic       disData,
    input logic [1:0] doneCom
);

    logic [3:0] hiCnt;  // consecutive disData samples so far

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) hiCnt <= '0;
        else if (disData) hiCnt <= hiCnt + 1'b1;
        else hiCnt <= '0;
    end

    validCtrlExcl: assert property (@(posedge clk) disable iff (!rstN)
        !(valid && control)) else $error("valid and control high together");

    dispNotLong: assert property (@(posedge clk) disable iff (!rstN)
        disData |-> hiCnt <= 4'(`DISPLAY_CYCLES)) else $error("display phase too long");

    dispNotShort: assert property (@(posedge clk) disable iff (!rstN)
        (!disData && hiCnt != 0) |-> hiCnt == 4'(`DISPLAY_CYCLES + 1))
        else $error("display phase too short");

    doneStays: assert property (@(posedge clk) disable iff (!rstN)
        $past(doneCom) != 2'b00 |-> doneCom != 2'b00) else $error("doneCom fell back to 00");

endmodule

bind masterExternal masterExternal_props u_props (
    .clk, .rstN, .valid, .control, .disData, .doneCom
);

/* tb/masterExternal_tb.sv */
`timescale 1ns/10ps
`include "busMaster_macros.svh"

module masterExternal_tb import busMaster_pkg::*; ();

    localparam slaveIdT slaveId = 3'b101;
    localparam int selDisp = 0;
    localparam int selArb  = 1;
    localparam int selCtrl = 2;

    logic clk, rstN, start, eoc, rD, ready, arbCont;
    logic [1:0] doneCom;
    dataT dataOut;
    logic disData, control, wrD, valid, arbSend;

    int unsigned modeQ[$];
    logic [15:0] wordQ[$];
    dataT        dispQ[$];
    logic [1:0]  doneQ[$];
    int numLines = 0;
    int errCount = 0;
    int protoErrs = 0;
    logic [31:0] rngState = 32'h967f;

    masterExternal #(.SLAVE_ID(slaveId)) u_dut (
        .clk, .rstN, .start, .eoc, .rD, .ready, .arbCont,
        .doneCom, .dataOut, .disData, .control, .wrD, .valid, .arbSend
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic logic pick(input int sel);
        case (sel)
            selDisp: return disData;
            selArb:  return arbSend;
            default: return control;
        endcase
    endfunction

    task automatic checkVal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errCount++;
            $display("FAIL %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic driveEdge();
        @(posedge clk);
        #2;     // inputs change just after the edge
    endtask

    task automatic waitHigh(input int sel, input int limit, input string what, output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < limit; n++) begin
            @(negedge clk);
            if (pick(sel)) begin
                ok = 1'b1;
                break;
            end
        end
        if (!ok) begin
            protoErrs++;
            $display("no %s seen within %0d cycles at %0t", what, limit, $time);
        end
    endtask

    task automatic loadTests();
        int fd;
        string line;
        int m, w, d, c;
        fd = $fopen("tb/masterExternal_tests.txt", "r");
        if (fd == 0) begin
            protoErrs++;
            $display("tests file could not be opened");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 4 || line.substr(0, 1) == "//") continue;
            if ($sscanf(line, "%h %h %h %h", m, w, d, c) == 4) begin
                modeQ.push_back(m);
                wordQ.push_back(16'(w));
                dispQ.push_back(8'(d));
                doneQ.push_back(2'(c));
            end
        end
        $fclose(fd);
    endtask

    ////////////////////
    // bus models
    ////////////////////

    task automatic startRun();
        rstN = 1'b0;
        start = 1'b0;
        eoc = 1'b0;
        rD = 1'b0;
        ready = 1'b0;
        arbCont = 1'b0;
        repeat (3) driveEdge();
        rstN = 1'b1;
        driveEdge();
        start = 1'b1;
        arbCont = 1'b1;     // bus busy while the first byte shows
        repeat (2) driveEdge();
        start = 1'b0;
    endtask

    task automatic checkDisplay(input dataT expByte);
        bit ok;
        int hi;
        waitHigh(selDisp, 80, "display phase", ok);
        if (ok) begin
            hi = 0;
            while (disData && hi < 20) begin
                checkVal(32'(dataOut), 32'(expByte), "dataOut during display");
                checkVal(32'(doneCom), 32'b11, "doneCom during display");
                hi++;
                @(negedge clk);
            end
            checkVal(hi, `DISPLAY_CYCLES + 1, "display length");
        end
    endtask

    task automatic getBus(input bit withGrant);
        bit ok;
        logic [5:0] reqBits;
        int i;
        if (arbCont) begin
            for (i = 0; i < 4; i++) begin
                @(negedge clk);
                checkVal(32'(arbSend), 0, "arbSend while arbCont high");
            end
            driveEdge();
            arbCont = 1'b0;
        end
        waitHigh(selArb, 20, "request on arbSend", ok);
        if (!ok) return;
        reqBits[5] = arbSend;
        for (i = 4; i >= 0; i--) begin
            @(negedge clk);
            reqBits[i] = arbSend;
        end
        checkVal(32'(reqBits), 32'({3'b111, slaveId}), "request word");
        if (!withGrant) return;
        repeat (2) driveEdge();
        arbCont = 1'b1;
        waitHigh(selArb, 10, "grant ack", ok);
        if (ok) begin
            @(negedge clk);
            checkVal(32'(arbSend), 0, "ack middle bit");
            @(negedge clk);
            checkVal(32'(arbSend), 1, "ack last bit");
        end
    endtask

    task automatic sendReply(input logic [15:0] word);
        int i;
        int gaps;
        for (i = 15; i >= 0; i--) begin
            gaps = int'(nextRand() % 3);
            repeat (gaps) begin
                driveEdge();
                ready = 1'b0;   // back-pressure gap
            end
            driveEdge();
            ready = 1'b1;
            rD = word[i];
        end
        driveEdge();
        ready = 1'b0;
        rD = 1'b0;
    endtask

    task automatic checkFrame(input bit isRead, input dataT wrByte, input logic [15:0] word);
        bit ok;
        logic [6:0] ctrlBits;
        dataT wrBits;
        int i;
        waitHigh(selCtrl, 20, "control word", ok);
        if (!ok) return;
        ctrlBits[6] = control;
        for (i = 5; i >= 0; i--) begin
            @(negedge clk);
            ctrlBits[i] = control;
        end
        checkVal(32'(ctrlBits), 32'({3'b111, slaveId, !isRead}), "control word");
        if (isRead) begin
            sendReply(word);
        end else begin
            for (i = 7; i >= 0; i--) begin
                @(negedge clk);
                checkVal(32'(valid), 1, "valid during write");
                wrBits[i] = wrD;
            end
            checkVal(32'(wrBits), 32'(wrByte), "write byte");
        end
        waitHigh(selCtrl, 10, "stop bit", ok);
        if (ok) begin
            @(negedge clk);
            checkVal(32'(control), 0, "stop bit length");
        end
    endtask

    task automatic releaseBus();
        bit ok;
        waitHigh(selArb, 10, "release pattern", ok);
        if (ok) begin
            @(negedge clk);
            checkVal(32'(arbSend), 1, "release third bit");
            @(negedge clk);
            checkVal(32'(arbSend), 0, "release last bit");
        end
        driveEdge();
        arbCont = 1'b0;
    endtask

    task automatic checkEnded(input dataT expByte);
        repeat (3) @(negedge clk);
        repeat (10) begin
            @(negedge clk);
            checkVal(32'(disData), 0, "disData after end");
            checkVal(32'(dataOut), 32'(expByte), "dataOut after end");
            checkVal(32'(doneCom), 32'b01, "doneCom after end");
            checkVal(32'(arbSend), 0, "arbSend after end");
            checkVal(32'(control), 0, "control after end");
        end
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        bit needStart;
        int idx;
        rstN = 1'b0;
        start = 1'b0;
        eoc = 1'b0;
        rD = 1'b0;
        ready = 1'b0;
        arbCont = 1'b0;
        needStart = 1'b1;
        loadTests();
        numLines = modeQ.size();
        for (idx = 0; idx < numLines; idx++) begin
            if (needStart) begin
                if (idx > 0) driveEdge();   // line up with the clock before a new reset
                startRun();
                needStart = 1'b0;
            end
            checkDisplay(dispQ[idx]);
            if (modeQ[idx] == 2) begin
                getBus(1'b0);   // stop before the grant
                driveEdge();
                eoc = 1'b1;
                driveEdge();
                eoc = 1'b0;
                arbCont = 1'b1;     // a request still pending would now be acked
                checkEnded(dispQ[idx]);
                needStart = 1'b1;
            end else begin
                getBus(1'b1);
                checkFrame(1'b0, dispQ[idx] + 8'd1, 16'h0);
                releaseBus();
                getBus(1'b1);
                checkFrame(1'b1, 8'h0, wordQ[idx]);
                releaseBus();
                if (modeQ[idx] == 1) begin
                    checkEnded(dispQ[idx]);
                    needStart = 1'b1;
                end
            end
            checkVal(32'(doneCom), 32'(doneQ[idx]), "doneCom after round");
        end
        $display("checks failed: %0d, protocol errors: %0d", errCount, protoErrs);
        if (errCount == 0 && protoErrs == 0 && numLines > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog allows 400 cycles per test line
    initial begin
        wait (numLines > 0);
        #(numLines * 400 * 20);
        $display("watchdog expired after %0d cycles, run stopped", numLines * 400);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* tb/masterExternal_tests.txt */
// columns (hex): mode, slave reply word, expected display byte, expected doneCom
// mode 0 good ack, 1 bad ack, 2 eoc while waiting for the grant
// a line after mode 1 or 2 starts a fresh run from reset
0 CC3C 0A 3
0 CC7E 3C 3
1 5A11 7E 1
0 CCA5 0A 3
2 0000 A5 1
0 CCFF 0A 3
0 CC00 FF 3
1 CD00 00 1

/* project.f */
+incdir+rtl
rtl/busMaster_pkg.sv
rtl/arbiterLink.sv
rtl/slaveLink.sv
rtl/masterCtrl.sv
rtl/masterExternal.sv
tb/masterExternal_props.sv
tb/masterExternal_tb.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module masterExternal_tb -o simv

run: compile
	./obj_dir/simv | tee sim.log
	@grep -q "TESTBENCH PASSED" sim.log || (echo "simulation did not pass, see sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
